/* hw/rv_isa_pkg.sv */
// ########################################
// RV32I subset definitions
// word, register index and instruction types,
// opcode, funct3 and funct7 codes, instruction
// field positions and the ALU function enum
// ########################################

package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // alu forms, ADDI shares F3_ADD
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;
  // branch, memory and system forms
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_WORD = 3'b010;
  localparam funct3_t F3_PRIV = 3'b000;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0100000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

  // lsb of each register-type field
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_t;

endpackage

/* hw/core_bus_pkg.sv */
// ########################################
// core bus and status definitions
// access size and response codes, core
// state enum and performance counter type
// ########################################

package core_bus_pkg;

  // access size, only word is ever driven
  typedef logic [1:0] bus_size_t;
  localparam bus_size_t SIZE_WORD = 2'b10;

  // bus response, anything nonzero is an error
  typedef logic [1:0] bus_resp_t;
  localparam bus_resp_t RESP_OKAY = 2'b00;

  // one instruction in flight, walked in this order
  typedef enum logic [2:0] {
    ST_FETCH     = 3'd0,
    ST_EXECUTE   = 3'd1,
    ST_MEMORY    = 3'd2,
    ST_WRITEBACK = 3'd3,
    // terminal states
    ST_HALT      = 3'd4,
    ST_FAULT     = 3'd5
  } core_state_t;

  // same width as the difftest trap counters
  typedef logic [63:0] count_t;

endpackage

/* hw/regfile.sv */
// ########################################
// regfile
// 32 x 32-bit registers, two async read
// ports, one sync write port, x0 fixed zero
// ########################################

module regfile (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  w_ena,
  input  rv_isa_pkg::reg_addr_t w_addr,
  input  rv_isa_pkg::word_t     w_data,
  input  rv_isa_pkg::reg_addr_t r_addr1,
  output rv_isa_pkg::word_t     r_data1,
  input  rv_isa_pkg::reg_addr_t r_addr2,
  output rv_isa_pkg::word_t     r_data2
);

  rv_isa_pkg::word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_ena && (w_addr != '0)) begin
      regs[w_addr] <= w_data;
    end
  end

  // x0 never written, so it reads back zero
  assign r_data1 = regs[r_addr1];
  assign r_data2 = regs[r_addr2];

endmodule

/* hw/exec_unit.sv */
// ########################################
// exec_unit
// decoder, ALU, branch compare and
// load/store address for the held instruction
// ########################################

module exec_unit (
  input  rv_isa_pkg::inst_t     inst,
  input  rv_isa_pkg::word_t     pc,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  output rv_isa_pkg::word_t     next_pc,
  output logic                  is_load,
  output logic                  is_store,
  output logic                  is_halt,
  output rv_isa_pkg::word_t     mem_addr,
  output rv_isa_pkg::word_t     store_data,
  output logic                  rd_wen,
  output rv_isa_pkg::reg_addr_t rd_addr,
  output rv_isa_pkg::word_t     alu_result
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_isa_pkg::word_t   imm_i, imm_s, imm_b, imm_u;
  rv_isa_pkg::word_t   alu_b;
  rv_isa_pkg::alu_op_t alu_op;
  logic                taken;

  assign opcode   = inst[6:0];
  assign rd_addr  = inst[rv_isa_pkg::RD_LSB +: 5];
  assign funct3   = inst[rv_isa_pkg::F3_LSB +: 3];
  assign rs1_addr = inst[rv_isa_pkg::RS1_LSB +: 5];
  assign rs2_addr = inst[rv_isa_pkg::RS2_LSB +: 5];
  assign funct7   = inst[rv_isa_pkg::F7_LSB +: 7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  // anything not matched below falls through as a no-op
  always_comb begin
    alu_op   = rv_isa_pkg::ALU_ADD;
    alu_b    = rs2_data;
    rd_wen   = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_halt  = 1'b0;
    taken    = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        alu_op = rv_isa_pkg::ALU_PASS_B;
        alu_b  = imm_u;
        rd_wen = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        alu_b  = imm_i;
        rd_wen = (funct3 == rv_isa_pkg::F3_ADD);
      end
      rv_isa_pkg::OP_REG: begin
        rd_wen = (funct7 == rv_isa_pkg::F7_BASE);
        case (funct3)
          rv_isa_pkg::F3_ADD: begin
            if (funct7 == rv_isa_pkg::F7_SUB) begin
              alu_op = rv_isa_pkg::ALU_SUB;
              rd_wen = 1'b1;
            end
          end
          rv_isa_pkg::F3_SLT: alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
          default: rd_wen = 1'b0;
        endcase
      end
      rv_isa_pkg::OP_LOAD: begin
        is_load = (funct3 == rv_isa_pkg::F3_WORD);
        rd_wen  = is_load;
      end
      rv_isa_pkg::OP_STORE: is_store = (funct3 == rv_isa_pkg::F3_WORD);
      rv_isa_pkg::OP_BRANCH: begin
        if (funct3 == rv_isa_pkg::F3_BEQ) taken = (rs1_data == rs2_data);
        if (funct3 == rv_isa_pkg::F3_BNE) taken = (rs1_data != rs2_data);
      end
      rv_isa_pkg::OP_SYSTEM: begin
        is_halt = (funct3 == rv_isa_pkg::F3_PRIV) && (inst[31:20] == rv_isa_pkg::FUNCT12_EBREAK)
                  && (rs1_addr == '0) && (rd_addr == '0);
      end
      default: ;
    endcase
  end

  always_comb begin
    case (alu_op)
      rv_isa_pkg::ALU_SUB:    alu_result = rs1_data - alu_b;
      rv_isa_pkg::ALU_AND:    alu_result = rs1_data & alu_b;
      rv_isa_pkg::ALU_OR:     alu_result = rs1_data | alu_b;
      rv_isa_pkg::ALU_XOR:    alu_result = rs1_data ^ alu_b;
      rv_isa_pkg::ALU_SLT:    alu_result = {31'b0, $signed(rs1_data) < $signed(alu_b)};
      rv_isa_pkg::ALU_PASS_B: alu_result = alu_b;
      default:                alu_result = rs1_data + alu_b;
    endcase
  end

  // stores use the split immediate
  assign mem_addr   = rs1_data + ((opcode == rv_isa_pkg::OP_STORE) ? imm_s : imm_i);
  assign store_data = rs2_data;
  assign next_pc    = taken ? (pc + imm_b) : (pc + 32'd4);

endmodule

/* hw/perf_counter.sv */
// ########################################
// perf_counter
// cycle and retired-instruction counters
// ########################################

module perf_counter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 retire,
  input  logic                 stopped,
  output core_bus_pkg::count_t cycle_count,
  output core_bus_pkg::count_t instr_count
);

  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= '0;
      instr_count <= '0;
    end else if (!stopped) begin
      cycle_count <= cycle_count + 64'd1;
      // retire is the commit strobe, so this lags it by one cycle
      instr_count <= instr_count + core_bus_pkg::count_t'(retire);
    end
  end

endmodule

/* hw/core_control.sv */
// ########################################
// core_control
// multi-cycle sequencer for fetch, execute,
// memory and writeback, with pc, instruction
// register, data request and commit report
// ########################################

module core_control #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                   clock,
  input  logic                   reset,
  // fetch port
  output logic                   if_rw_valid,
  input  logic                   if_rw_ready,
  output rv_isa_pkg::word_t      if_rw_addr,
  input  rv_isa_pkg::inst_t      if_r_data,
  input  core_bus_pkg::bus_resp_t if_rw_resp,
  // data port
  output logic                   mem_rw_valid,
  input  logic                   mem_rw_ready,
  output logic                   mem_rw_req,
  output rv_isa_pkg::word_t      mem_rw_addr,
  output rv_isa_pkg::word_t      mem_w_data,
  input  rv_isa_pkg::word_t      mem_r_data,
  input  core_bus_pkg::bus_resp_t mem_rw_resp,
  // execution results
  output rv_isa_pkg::inst_t      inst,
  output rv_isa_pkg::word_t      pc,
  input  rv_isa_pkg::word_t      next_pc,
  input  logic                   is_load,
  input  logic                   is_store,
  input  logic                   is_halt,
  input  rv_isa_pkg::word_t      mem_addr,
  input  rv_isa_pkg::word_t      store_data,
  input  logic                   rd_wen,
  input  rv_isa_pkg::reg_addr_t  rd_addr,
  input  rv_isa_pkg::word_t      alu_result,
  // register file write port
  output logic                   reg_wr_ena,
  output rv_isa_pkg::reg_addr_t  reg_wr_addr,
  output rv_isa_pkg::word_t      reg_wr_data,
  // commit report and status
  output logic                   commit_valid,
  output rv_isa_pkg::word_t      commit_pc,
  output rv_isa_pkg::inst_t      commit_inst,
  output logic                   commit_wen,
  output rv_isa_pkg::reg_addr_t  commit_wdest,
  output rv_isa_pkg::word_t      commit_wdata,
  output logic                   halted,
  output logic                   fault
);

  core_bus_pkg::core_state_t state;
  rv_isa_pkg::word_t         load_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= core_bus_pkg::ST_FETCH;
      pc    <= RESET_PC;
    end else begin
      case (state)
        core_bus_pkg::ST_FETCH: begin
          if (if_rw_ready) begin
            state <= (if_rw_resp != core_bus_pkg::RESP_OKAY) ? core_bus_pkg::ST_FAULT
                                                             : core_bus_pkg::ST_EXECUTE;
          end
        end
        core_bus_pkg::ST_EXECUTE: begin
          state <= (is_load || is_store) ? core_bus_pkg::ST_MEMORY
                                         : core_bus_pkg::ST_WRITEBACK;
        end
        core_bus_pkg::ST_MEMORY: begin
          if (mem_rw_ready) begin
            state <= (mem_rw_resp != core_bus_pkg::RESP_OKAY) ? core_bus_pkg::ST_FAULT
                                                               : core_bus_pkg::ST_WRITEBACK;
          end
        end
        core_bus_pkg::ST_WRITEBACK: begin
          pc    <= next_pc;
          state <= is_halt ? core_bus_pkg::ST_HALT : core_bus_pkg::ST_FETCH;
        end
        // halt and fault are sticky until reset
        default: state <= state;
      endcase
    end
  end

  // instruction, request and load data only change at their handshakes
  always_ff @(posedge clock) begin
    if (state == core_bus_pkg::ST_FETCH && if_rw_ready) begin
      inst <= if_r_data;
    end
    if (state == core_bus_pkg::ST_EXECUTE) begin
      mem_rw_req  <= is_store;
      mem_rw_addr <= mem_addr;
      mem_w_data  <= store_data;
    end
    if (state == core_bus_pkg::ST_MEMORY && mem_rw_ready) begin
      load_data <= mem_r_data;
    end
  end

  assign if_rw_valid  = (state == core_bus_pkg::ST_FETCH);
  assign if_rw_addr   = pc;
  assign mem_rw_valid = (state == core_bus_pkg::ST_MEMORY);

  // inst is held through writeback, so decode outputs are still valid
  assign reg_wr_ena  = (state == core_bus_pkg::ST_WRITEBACK) && rd_wen;
  assign reg_wr_addr = rd_addr;
  assign reg_wr_data = is_load ? load_data : alu_result;

  assign commit_valid = (state == core_bus_pkg::ST_WRITEBACK);
  assign commit_pc    = pc;
  assign commit_inst  = inst;
  assign commit_wen   = rd_wen;
  assign commit_wdest = rd_addr;
  assign commit_wdata = reg_wr_data;

  assign halted = (state == core_bus_pkg::ST_HALT);
  assign fault  = (state == core_bus_pkg::ST_FAULT);

endmodule

/* hw/cpu.sv */
// ########################################
// cpu
// RV32I subset core top level, wires the
// sequencer, execute unit, register file
// and counters to the fetch and data buses
// ########################################

module cpu #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                    clock,
  input  logic                    reset,
  // fetch port
  output logic                    if_rw_valid,
  input  logic                    if_rw_ready,
  input  rv_isa_pkg::inst_t       if_r_data,
  output rv_isa_pkg::word_t       if_rw_addr,
  output core_bus_pkg::bus_size_t if_rw_size,
  input  core_bus_pkg::bus_resp_t if_rw_resp,
  // data port
  output logic                    mem_rw_valid,
  input  logic                    mem_rw_ready,
  output logic                    mem_rw_req,
  input  rv_isa_pkg::word_t       mem_r_data,
  output rv_isa_pkg::word_t       mem_w_data,
  output rv_isa_pkg::word_t       mem_rw_addr,
  output core_bus_pkg::bus_size_t mem_rw_size,
  input  core_bus_pkg::bus_resp_t mem_rw_resp,
  // commit report
  output logic                    commit_valid,
  output rv_isa_pkg::word_t       commit_pc,
  output rv_isa_pkg::inst_t       commit_inst,
  output logic                    commit_wen,
  output rv_isa_pkg::reg_addr_t   commit_wdest,
  output rv_isa_pkg::word_t       commit_wdata,
  // status
  output logic                    halted,
  output logic                    fault,
  output core_bus_pkg::count_t    cycle_count,
  output core_bus_pkg::count_t    instr_count
);

  // control <-> execute
  rv_isa_pkg::inst_t     inst;
  rv_isa_pkg::word_t     pc, next_pc, mem_addr, store_data, alu_result;
  logic                  is_load, is_store, is_halt, rd_wen;
  rv_isa_pkg::reg_addr_t rd_addr;

  // register file ports
  rv_isa_pkg::reg_addr_t rs1_addr, rs2_addr, reg_wr_addr;
  rv_isa_pkg::word_t     rs1_data, rs2_data, reg_wr_data;
  logic                  reg_wr_ena;

  // word is the only access size
  assign if_rw_size  = core_bus_pkg::SIZE_WORD;
  assign mem_rw_size = core_bus_pkg::SIZE_WORD;

  core_control #(
    .RESET_PC (RESET_PC)
  ) control_i (
    .clock, .reset,
    .if_rw_valid, .if_rw_ready, .if_rw_addr, .if_r_data, .if_rw_resp,
    .mem_rw_valid, .mem_rw_ready, .mem_rw_req, .mem_rw_addr, .mem_w_data,
    .mem_r_data, .mem_rw_resp,
    .inst, .pc, .next_pc, .is_load, .is_store, .is_halt,
    .mem_addr, .store_data, .rd_wen, .rd_addr, .alu_result,
    .reg_wr_ena, .reg_wr_addr, .reg_wr_data,
    .commit_valid, .commit_pc, .commit_inst, .commit_wen, .commit_wdest, .commit_wdata,
    .halted, .fault
  );

  exec_unit exec_i (
    .inst, .pc,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .next_pc, .is_load, .is_store, .is_halt,
    .mem_addr, .store_data, .rd_wen, .rd_addr, .alu_result
  );

  regfile regfile_i (
    .clock   (clock),
    .reset   (reset),
    .w_ena   (reg_wr_ena),
    .w_addr  (reg_wr_addr),
    .w_data  (reg_wr_data),
    .r_addr1 (rs1_addr),
    .r_data1 (rs1_data),
    .r_addr2 (rs2_addr),
    .r_data2 (rs2_data)
  );

  // counters stop for good on halt or fault
  perf_counter perf_i (
    .clock       (clock),
    .reset       (reset),
    .retire      (commit_valid),
    .stopped     (halted | fault),
    .cycle_count (cycle_count),
    .instr_count (instr_count)
  );

endmodule

/* test/cpu_asserts.sv */
// ########################################
// cpu_asserts
// handshake, state transition and commit
// rules, bound into core_control
// ########################################

module cpu_asserts (
  input logic                      clock,
  input logic                      reset,
  input core_bus_pkg::core_state_t state,
  input logic                      if_rw_valid,
  input logic                      if_rw_ready,
  input rv_isa_pkg::word_t         if_rw_addr,
  input logic                      mem_rw_valid,
  input logic                      mem_rw_ready,
  input logic                      mem_rw_req,
  input rv_isa_pkg::word_t         mem_rw_addr,
  input rv_isa_pkg::word_t         mem_w_data,
  input logic                      commit_valid,
  input logic                      halted,
  input logic                      fault
);

  // request held stable until ready
  fetch_hold: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr))
    else $error("fetch request changed before ready");

  data_hold: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid && !mem_rw_ready |=> mem_rw_valid && $stable(mem_rw_addr)
      && $stable(mem_rw_req) && $stable(mem_w_data))
    else $error("data request changed before ready");

  // each state steps only to a legal successor
  legal_state: assert property (@(posedge clock) disable iff (reset)
    ($past(state) == core_bus_pkg::ST_FETCH && state inside {core_bus_pkg::ST_FETCH,
        core_bus_pkg::ST_EXECUTE, core_bus_pkg::ST_FAULT})
    || ($past(state) == core_bus_pkg::ST_EXECUTE && state inside {core_bus_pkg::ST_MEMORY,
        core_bus_pkg::ST_WRITEBACK})
    || ($past(state) == core_bus_pkg::ST_MEMORY && state inside {core_bus_pkg::ST_MEMORY,
        core_bus_pkg::ST_WRITEBACK, core_bus_pkg::ST_FAULT})
    || ($past(state) == core_bus_pkg::ST_WRITEBACK && state inside {core_bus_pkg::ST_FETCH,
        core_bus_pkg::ST_HALT})
    || ($past(state) inside {core_bus_pkg::ST_HALT, core_bus_pkg::ST_FAULT}
        && state == $past(state)))
    else $error("illegal core state");

  no_commit_stopped: assert property (@(posedge clock) disable iff (reset)
    halted || fault |=> !commit_valid)
    else $error("commit while stopped");

endmodule

bind core_control cpu_asserts asserts_i (
  .clock, .reset, .state,
  .if_rw_valid, .if_rw_ready, .if_rw_addr,
  .mem_rw_valid, .mem_rw_ready, .mem_rw_req, .mem_rw_addr, .mem_w_data,
  .commit_valid, .halted, .fault
);

/* test/tb_cpu.sv */
// ########################################
// tb_cpu
// clock and reset, fetch and data bus
// responders with random ready delays,
// random RV32I subset instruction stream,
// reference model and compare tasks
// ########################################

module tb_cpu;

  localparam int NUM_INSTS  = 400;
  localparam int WAIT_LIMIT = 50;
  localparam rv_isa_pkg::inst_t EBREAK_INST = 32'h00100073;

  logic                    clock;
  logic                    reset;
  logic                    if_rw_valid;
  logic                    if_rw_ready;
  rv_isa_pkg::inst_t       if_r_data;
  rv_isa_pkg::word_t       if_rw_addr;
  core_bus_pkg::bus_size_t if_rw_size;
  core_bus_pkg::bus_resp_t if_rw_resp;
  logic                    mem_rw_valid;
  logic                    mem_rw_ready;
  logic                    mem_rw_req;
  rv_isa_pkg::word_t       mem_r_data;
  rv_isa_pkg::word_t       mem_w_data;
  rv_isa_pkg::word_t       mem_rw_addr;
  core_bus_pkg::bus_size_t mem_rw_size;
  core_bus_pkg::bus_resp_t mem_rw_resp;
  logic                    commit_valid;
  rv_isa_pkg::word_t       commit_pc;
  rv_isa_pkg::inst_t       commit_inst;
  logic                    commit_wen;
  rv_isa_pkg::reg_addr_t   commit_wdest;
  rv_isa_pkg::word_t       commit_wdata;
  logic                    halted;
  logic                    fault;
  core_bus_pkg::count_t    cycle_count;
  core_bus_pkg::count_t    instr_count;

  integer seed;
  // dmem is what the data responder serves, model_mem is the model's copy
  rv_isa_pkg::word_t    dmem [64];
  rv_isa_pkg::word_t    model_mem [64];
  rv_isa_pkg::word_t    model_regs [32];
  rv_isa_pkg::word_t    model_pc;
  core_bus_pkg::count_t retired;
  core_bus_pkg::count_t fetch_count;
  core_bus_pkg::count_t commit_count = '0;
  core_bus_pkg::count_t commit_base;
  core_bus_pkg::count_t cycles_run;

  // expected results of the instruction in flight
  logic                  exp_wen;
  logic                  exp_mem;
  logic                  exp_store;
  rv_isa_pkg::reg_addr_t exp_wdest;
  rv_isa_pkg::word_t     exp_wdata;
  rv_isa_pkg::word_t     exp_next_pc;
  rv_isa_pkg::word_t     exp_addr;
  rv_isa_pkg::word_t     exp_sdata;

  cpu #(.RESET_PC('0)) dut_i (
    .clock, .reset,
    .if_rw_valid, .if_rw_ready, .if_r_data, .if_rw_addr, .if_rw_size, .if_rw_resp,
    .mem_rw_valid, .mem_rw_ready, .mem_rw_req, .mem_r_data, .mem_w_data,
    .mem_rw_addr, .mem_rw_size, .mem_rw_resp,
    .commit_valid, .commit_pc, .commit_inst, .commit_wen, .commit_wdest, .commit_wdata,
    .halted, .fault, .cycle_count, .instr_count
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    if (!reset && commit_valid) begin
      commit_count <= commit_count + 64'd1;
    end
  end

  // clock edges since the end of reset
  always @(posedge clock) begin
    if (reset) begin
      cycles_run <= '0;
    end else begin
      cycles_run <= cycles_run + 64'd1;
    end
  end

  task automatic report_failure(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(string what, rv_isa_pkg::word_t got, rv_isa_pkg::word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_reg(string what, rv_isa_pkg::reg_addr_t got,
                           rv_isa_pkg::reg_addr_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got x%0d expected x%0d", $time, what, got, exp));
    end
  endtask

  task automatic check_count(string what, core_bus_pkg::count_t got,
                             core_bus_pkg::count_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  // all sampling and driving happens 2 units after the rising edge
  task automatic step();
    @(posedge clock);
    #2;
  endtask

  function automatic int unsigned urand(int unsigned n);
    urand = $unsigned($random(seed)) % n;
  endfunction

  function automatic rv_isa_pkg::word_t alu_model(rv_isa_pkg::alu_op_t op,
                                                  rv_isa_pkg::word_t a, rv_isa_pkg::word_t b);
    case (op)
      rv_isa_pkg::ALU_SUB:    alu_model = a - b;
      rv_isa_pkg::ALU_AND:    alu_model = a & b;
      rv_isa_pkg::ALU_OR:     alu_model = a | b;
      rv_isa_pkg::ALU_XOR:    alu_model = a ^ b;
      rv_isa_pkg::ALU_SLT:    alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_isa_pkg::ALU_PASS_B: alu_model = b;
      default:                alu_model = a + b;
    endcase
  endfunction

  // registers x0 to x7, memory offsets from x0 inside the 64-word memory
  function automatic rv_isa_pkg::inst_t gen_inst();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [12:0] off;
    rv_isa_pkg::funct3_t f3;
    rv_isa_pkg::funct7_t f7;
    rd  = 5'(urand(8));
    rs1 = 5'(urand(8));
    rs2 = 5'(urand(8));
    imm = 12'(urand(4096));
    off = 13'((urand(32) - 16) * 4);
    f7  = rv_isa_pkg::F7_BASE;
    case (urand(10))
      0: gen_inst = {20'(urand(1 << 20)), rd, rv_isa_pkg::OP_LUI};
      2, 3, 4: begin
        case (urand(6))
          0: f3 = rv_isa_pkg::F3_ADD;
          1: begin
            f3 = rv_isa_pkg::F3_ADD;
            f7 = rv_isa_pkg::F7_SUB;
          end
          2: f3 = rv_isa_pkg::F3_AND;
          3: f3 = rv_isa_pkg::F3_OR;
          4: f3 = rv_isa_pkg::F3_XOR;
          default: f3 = rv_isa_pkg::F3_SLT;
        endcase
        gen_inst = {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
      end
      5: begin
        imm = 12'(urand(64) * 4);
        gen_inst = {imm, 5'd0, rv_isa_pkg::F3_WORD, rd, rv_isa_pkg::OP_LOAD};
      end
      6: begin
        imm = 12'(urand(64) * 4);
        gen_inst = {imm[11:5], rs2, 5'd0, rv_isa_pkg::F3_WORD, imm[4:0], rv_isa_pkg::OP_STORE};
      end
      7, 8: begin
        f3 = urand(2) == 0 ? rv_isa_pkg::F3_BEQ : rv_isa_pkg::F3_BNE;
        gen_inst = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
      end
      default: gen_inst = {imm, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_IMM};
    endcase
  endfunction

  task automatic predict(rv_isa_pkg::inst_t inst);
    rv_isa_pkg::word_t   a;
    rv_isa_pkg::word_t   b;
    rv_isa_pkg::word_t   imm_i;
    rv_isa_pkg::word_t   imm_s;
    rv_isa_pkg::word_t   imm_b;
    rv_isa_pkg::alu_op_t op;
    a = model_regs[inst[19:15]];
    b = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    exp_wen = 1'b0;
    exp_mem = 1'b0;
    exp_store = 1'b0;
    exp_wdest = inst[11:7];
    exp_wdata = '0;
    exp_next_pc = model_pc + 32'd4;
    exp_addr = '0;
    exp_sdata = b;
    case (inst[6:0])
      rv_isa_pkg::OP_LUI: begin
        exp_wen = 1'b1;
        exp_wdata = {inst[31:12], 12'b0};
      end
      rv_isa_pkg::OP_IMM: begin
        exp_wen = 1'b1;
        exp_wdata = alu_model(rv_isa_pkg::ALU_ADD, a, imm_i);
      end
      rv_isa_pkg::OP_REG: begin
        case (inst[14:12])
          rv_isa_pkg::F3_AND: op = rv_isa_pkg::ALU_AND;
          rv_isa_pkg::F3_OR:  op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_XOR: op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_SLT: op = rv_isa_pkg::ALU_SLT;
          default: op = inst[30] ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
        endcase
        exp_wen = 1'b1;
        exp_wdata = alu_model(op, a, b);
      end
      rv_isa_pkg::OP_LOAD: begin
        exp_wen = 1'b1;
        exp_mem = 1'b1;
        exp_addr = a + imm_i;
        exp_wdata = model_mem[exp_addr[7:2]];
      end
      rv_isa_pkg::OP_STORE: begin
        exp_mem = 1'b1;
        exp_store = 1'b1;
        exp_addr = a + imm_s;
      end
      rv_isa_pkg::OP_BRANCH: begin
        if ((inst[12] == 1'b0) ? (a == b) : (a != b)) begin
          exp_next_pc = model_pc + imm_b;
        end
      end
      default: ;
    endcase
  endtask

  // one instruction from fetch to commit, bad answers the fetch with an error
  task automatic run_one(rv_isa_pkg::inst_t inst, logic bad);
    int n;
    n = 0;
    while (!if_rw_valid) begin
      if (n == WAIT_LIMIT) report_failure("timeout while waiting for a fetch request");
      step();
      n++;
    end
    check_word("fetch address", if_rw_addr, model_pc);
    check_word("fetch size", {30'b0, if_rw_size}, {30'b0, core_bus_pkg::SIZE_WORD});
    repeat (urand(4)) step();
    if_rw_ready = 1'b1;
    if_r_data = inst;
    if_rw_resp = bad ? 2'b10 : core_bus_pkg::RESP_OKAY;
    step();
    if_rw_ready = 1'b0;
    if_rw_resp = core_bus_pkg::RESP_OKAY;
    if (!bad) begin
      fetch_count++;
      predict(inst);
      if (exp_mem) begin
        n = 0;
        while (!mem_rw_valid) begin
          if (n == WAIT_LIMIT) report_failure("timeout while waiting for a data request");
          step();
          n++;
        end
        check_word("data address", mem_rw_addr, exp_addr);
        check_word("data size", {30'b0, mem_rw_size}, {30'b0, core_bus_pkg::SIZE_WORD});
        check_word("data write flag", {31'b0, mem_rw_req}, {31'b0, exp_store});
        if (exp_store) check_word("store data", mem_w_data, exp_sdata);
        repeat (urand(4)) step();
        mem_rw_ready = 1'b1;
        mem_rw_resp = core_bus_pkg::RESP_OKAY;
        mem_r_data = dmem[mem_rw_addr[7:2]];
        if (mem_rw_req) dmem[mem_rw_addr[7:2]] = mem_w_data;
        step();
        mem_rw_ready = 1'b0;
      end
      n = 0;
      while (!commit_valid) begin
        if (n == WAIT_LIMIT) report_failure("timeout while waiting for a commit");
        step();
        n++;
      end
      check_word("commit pc", commit_pc, model_pc);
      check_word("commit instruction", commit_inst, inst);
      check_word("commit write enable", {31'b0, commit_wen}, {31'b0, exp_wen});
      if (exp_wen) begin
        check_reg("commit destination", commit_wdest, exp_wdest);
        check_word("commit data", commit_wdata, exp_wdata);
        if (exp_wdest != '0) model_regs[exp_wdest] = exp_wdata;
      end
      if (exp_store) model_mem[exp_addr[7:2]] = exp_sdata;
      model_pc = exp_next_pc;
      retired++;
    end
  endtask

  task automatic reset_core();
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    model_pc = '0;
    retired = '0;
    fetch_count = '0;
    commit_base = commit_count;
  endtask

  task automatic watch_idle(logic check_halted);
    repeat (20) begin
      step();
      if (if_rw_valid || mem_rw_valid) report_failure("bus request after the core stopped");
      if (commit_valid) report_failure("commit after the core stopped");
      if (check_halted ? !halted : !fault) report_failure("stop status dropped");
    end
  endtask

  initial begin
    int n;
    core_bus_pkg::count_t stop_cycles;
    seed = 32'h8731a6ba;
    reset = 1'b1;
    if_rw_ready = 1'b0;
    if_r_data = '0;
    if_rw_resp = core_bus_pkg::RESP_OKAY;
    mem_rw_ready = 1'b0;
    mem_r_data = '0;
    mem_rw_resp = core_bus_pkg::RESP_OKAY;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = (rv_isa_pkg::word_t'(i) * 32'h9e3779b9) ^ 32'h0f1e2d3c;
      model_mem[i] = dmem[i];
    end
    reset_core();

    // run until EBREAK halts the core
    for (int k = 0; k < NUM_INSTS; k++) run_one(gen_inst(), 1'b0);
    run_one(EBREAK_INST, 1'b0);
    n = 0;
    while (!halted) begin
      if (n == WAIT_LIMIT) report_failure("timeout while waiting for halted");
      step();
      n++;
    end
    check_count("cycle count at halt", cycle_count, cycles_run);
    stop_cycles = cycles_run;
    watch_idle(1'b1);
    check_count("cycle count after halt", cycle_count, stop_cycles);
    check_count("retired count at halt", instr_count, retired);
    check_count("commits per fetch", commit_count - commit_base, fetch_count);

    // second run ends on a fetch error
    reset_core();
    if (halted || fault) report_failure("status still set after reset");
    for (int k = 0; k < 30; k++) run_one(gen_inst(), 1'b0);
    run_one(gen_inst(), 1'b1);
    n = 0;
    while (!fault) begin
      if (n == WAIT_LIMIT) report_failure("timeout while waiting for fault");
      step();
      n++;
    end
    check_count("cycle count at fault", cycle_count, cycles_run);
    stop_cycles = cycles_run;
    watch_idle(1'b0);
    check_count("cycle count after fault", cycle_count, stop_cycles);
    check_count("retired count at fault", instr_count, retired);
    check_count("commits before fault", commit_count - commit_base, retired);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* vlog.f */
hw/rv_isa_pkg.sv
hw/core_bus_pkg.sv
hw/regfile.sv
hw/exec_unit.sv
hw/perf_counter.sv
hw/core_control.sv
hw/cpu.sv
test/cpu_asserts.sv
test/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cpu
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
